// File: include/acc8_macros.svh
`ifndef ACC8_MACROS_SVH
`define ACC8_MACROS_SVH

// ********************
// Datapath sizing
// ********************

// Width of one data word
`define ACC8_DATA_W 8

// Registers in the bank
`define ACC8_REG_N 16

// ALU opcode field
`define ACC8_OP_W 3

`endif

// File: hdl/reg_pkg.sv
`default_nettype none

`include "acc8_macros.svh"

// Register file types
package reg_pkg;

   // One data word, also the accumulator
   typedef logic [`ACC8_DATA_W-1:0] data_t;

   // Register number, sized from the bank depth
   typedef logic [$clog2(`ACC8_REG_N)-1:0] reg_idx_t;

endpackage

`default_nettype wire

// File: hdl/alu_pkg.sv
`default_nettype none

`include "acc8_macros.svh"

// ALU types
package alu_pkg;
   import reg_pkg::*;

   // Opcode order is also the result mux input order
   typedef enum logic [`ACC8_OP_W-1:0] {
      OP_PASS = 3'd0, // Operand straight through
      OP_ADD  = 3'd1, // acc + operand
      OP_SUB  = 3'd2, // acc - operand
      OP_AND  = 3'd3,
      OP_OR   = 3'd4,
      OP_XOR  = 3'd5,
      OP_INC  = 3'd6, // acc + 1
      OP_NOT  = 3'd7  // ~acc
   } alu_op_t;

   // Carry sits above the word, so a 9 bit sum maps straight in
   typedef struct packed {
      logic  carry;
      data_t value;
   } alu_out_t;

endpackage

`default_nettype wire

// File: hdl/gate_mux.sv
`default_nettype none

// Decode, gate, then OR
module gate_mux #(
   parameter type payload_t = logic,
   parameter int  n_in      = 2
) (
   input  wire logic                                   clk,  // Only for the check
   input  wire logic [((n_in > 1) ? $clog2(n_in) : 1)-1:0] sel,
   input  payload_t                                    din [n_in],
   output payload_t                                    dout
);

   localparam int sel_w = (n_in > 1) ? $clog2(n_in) : 1;
   localparam int pw    = $bits(payload_t);

   logic [n_in-1:0] line;        // One-hot select lines
   logic [pw-1:0]   gated [n_in]; // Inputs after the AND stage
   logic [pw-1:0]   merged;       // OR of all gated inputs

   // ********************
   // Decoder
   // ********************

   always_comb begin
      for (int i = 0; i < n_in; i++) begin
         line[i] = (sel == sel_w'(i)); // At most one line high
      end
   end

   // ********************
   // AND stage
   // ********************

   // Enable replicated across the payload width
   for (genvar g = 0; g < n_in; g++) begin : g_and
      assign gated[g] = pw'(din[g]) & {pw{line[g]}};
   end

   // ********************
   // OR stage
   // ********************

   always_comb begin
      merged = '0;
      for (int i = 0; i < n_in; i++) begin
         merged = merged | gated[i]; // Unselected inputs are all zero
      end
   end

   assign dout = payload_t'(merged);

   // Out of range select would give zero, not a real input
   a_sel_valid : assert property (
      @(posedge clk) !$isunknown(sel) && (int'(sel) < n_in)
   ) else $error("gate_mux sel out of range or unknown");

endmodule

`default_nettype wire

// File: hdl/reg_bank.sv
`default_nettype none

`include "acc8_macros.svh"

// Register bank, one write port and one read port
module reg_bank import reg_pkg::*; (
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic we,      // Write strobe
   input  reg_idx_t  wr_idx,  // Write address
   input  data_t     wr_data,
   input  reg_idx_t  rd_idx,  // Read address
   output data_t     rd_data  // Combinational read
);

   data_t regs [`ACC8_REG_N]; // Storage

   // ********************
   // Write port
   // ********************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `ACC8_REG_N; i++) begin
            regs[i] <= '0; // Whole bank clears
         end
      end else if (we) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // ********************
   // Read port
   // ********************

   // Read sees the value before this edge, no bypass
   gate_mux #(
      .payload_t (data_t),
      .n_in      (`ACC8_REG_N)
   ) i_rd_mux (
      .clk  (clk),
      .sel  (rd_idx),
      .din  (regs),
      .dout (rd_data)
   );

   // Unknown address would corrupt an unknown register
   a_wr_idx_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      we |-> !$isunknown(wr_idx)
   ) else $error("reg_bank write with unknown index");

endmodule

`default_nettype wire

// File: hdl/alu8.sv
`default_nettype none

`include "acc8_macros.svh"

// 8 bit ALU, every result formed at once, then picked
module alu8 import reg_pkg::*, alu_pkg::*; (
   input  wire logic clk,  // Check only
   input  alu_op_t   op,
   input  data_t     a,    // Accumulator side
   input  data_t     b,    // Operand side
   output alu_out_t  res
);

   localparam int n_ops = 1 << `ACC8_OP_W;

   alu_out_t cand [n_ops]; // One candidate per opcode

   logic [`ACC8_DATA_W:0] sum_add; // Extra bit is the carry
   logic [`ACC8_DATA_W:0] sum_sub;
   logic [`ACC8_DATA_W:0] sum_inc;

   // ********************
   // Arithmetic
   // ********************

   assign sum_add = {1'b0, a} + {1'b0, b};
   // a + ~b + 1, top bit is the inverted borrow
   assign sum_sub = {1'b0, a} + {1'b0, ~b} + 1'b1;
   assign sum_inc = {1'b0, a} + 1'b1;

   // ********************
   // Candidates
   // ********************

   always_comb begin
      cand[OP_PASS] = '{carry: 1'b0, value: b};
      cand[OP_ADD]  = alu_out_t'(sum_add);
      cand[OP_SUB]  = alu_out_t'(sum_sub);
      cand[OP_AND]  = '{carry: 1'b0, value: a & b};
      cand[OP_OR]   = '{carry: 1'b0, value: a | b};
      cand[OP_XOR]  = '{carry: 1'b0, value: a ^ b};
      cand[OP_INC]  = alu_out_t'(sum_inc); // Carry out of 8'hff
      cand[OP_NOT]  = '{carry: 1'b0, value: ~a};
   end

   // Opcode drives the select directly
   gate_mux #(
      .payload_t (alu_out_t),
      .n_in      (n_ops)
   ) i_res_mux (
      .clk  (clk),
      .sel  (op),
      .din  (cand),
      .dout (res)
   );

   // Bad opcode would make the accumulator unknown
   a_op_known : assert property (
      @(posedge clk) !$isunknown(op)
   ) else $error("alu8 opcode unknown");

endmodule

`default_nettype wire

// File: hdl/acc_datapath.sv
`default_nettype none

// Accumulator datapath running one instruction per clock
module acc_datapath import reg_pkg::*, alu_pkg::*; (
   input  wire logic clk,
   input  wire logic rst_n,
   input  alu_op_t   op,
   input  wire logic use_imm, // 1 takes imm and 0 takes register rs
   input  data_t     imm,
   input  reg_idx_t  rs,      // Operand register
   input  wire logic acc_en,  // Load acc and carry
   input  wire logic reg_we,  // Store acc into rd
   input  reg_idx_t  rd,
   output data_t     acc,
   output logic      carry
);

   data_t    rd_data;     // Bank read
   data_t    opnd_in [2]; // Operand choices
   data_t    operand;
   alu_out_t alu_res;

   // ********************
   // Register bank
   // ********************

   // Stores the pre-edge acc
   reg_bank i_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .we      (reg_we),
      .wr_idx  (rd),
      .wr_data (acc),
      .rd_idx  (rs),
      .rd_data (rd_data)
   );

   // ********************
   // Operand select
   // ********************

   assign opnd_in[0] = rd_data; // use_imm low
   assign opnd_in[1] = imm;

   gate_mux #(
      .payload_t (data_t),
      .n_in      (2)
   ) i_opnd_mux (
      .clk  (clk),
      .sel  (use_imm),
      .din  (opnd_in),
      .dout (operand)
   );

   alu8 i_alu (
      .clk (clk),
      .op  (op),
      .a   (acc),
      .b   (operand),
      .res (alu_res)
   );

   // Accumulator and carry
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc   <= '0;
         carry <= 1'b0;
      end else if (acc_en) begin
         acc   <= alu_res.value; // Visible after this edge
         carry <= alu_res.carry;
      end
   end

   // Unknown enables would smear X into acc or the bank
   a_ctrl_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      !$isunknown({acc_en, reg_we})
   ) else $error("acc_datapath acc_en or reg_we unknown");

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

// Free running clock and power-on reset
module tb_clock #(
   parameter int reset_cycles = 5
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk; // 100 unit period
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: verification/acc_datapath_tb.sv
`default_nettype none

`include "acc8_macros.svh"

// Testbench for the accumulator datapath
module acc_datapath_tb import reg_pkg::*, alu_pkg::*; ();

   localparam int reset_cycles = 5;

   // Vectors per test
   localparam int n_reset_reads = `ACC8_REG_N;
   localparam int n_opcodes     = 8 * 8 * 2;           // 8 ops over 8 pairs, load and op
   localparam int n_roundtrip   = `ACC8_REG_N * 3 + 1; // Write pairs then a clear and reads
   localparam int n_same_cycle  = `ACC8_REG_N * 3;
   localparam int n_hold        = 10;
   localparam int n_random      = 2000;
   localparam int total_vectors = n_reset_reads + n_opcodes + n_roundtrip
                                  + n_same_cycle + n_hold + n_random;
   localparam int timeout       = (reset_cycles + total_vectors + 20) * 100;

   // Operand pairs for the opcode sweep
   localparam logic [7:0] pair_a [8] = '{8'h00, 8'hff, 8'h80, 8'h5a,
                                         8'h01, 8'hff, 8'h7f, 8'h10};
   localparam logic [7:0] pair_b [8] = '{8'h00, 8'h01, 8'h80, 8'ha5,
                                         8'h02, 8'hff, 8'h01, 8'h10};

   logic     clk;
   logic     rst_n;
   alu_op_t  op;
   logic     use_imm;
   data_t    imm;
   reg_idx_t rs;
   logic     acc_en;
   logic     reg_we;
   reg_idx_t rd;
   data_t    acc;
   logic     carry;

   // Reference state
   data_t       model_acc;
   logic        model_carry;
   data_t       model_regs [`ACC8_REG_N];
   data_t       model_opnd;
   logic [8:0]  model_next;

   logic [31:0] lfsr_state = 32'hae8f;
   int          check_count = 0;
   int          error_count = 0;

   tb_clock #(
      .reset_cycles (reset_cycles)
   ) i_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   acc_datapath i_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .op      (op),
      .use_imm (use_imm),
      .imm     (imm),
      .rs      (rs),
      .acc_en  (acc_en),
      .reg_we  (reg_we),
      .rd      (rd),
      .acc     (acc),
      .carry   (carry)
   );

   // ********************
   // Reference model
   // ********************

   // {carry, value} straight from the opcode rules
   function automatic logic [8:0] ref_alu(input alu_op_t o, input data_t a, input data_t b);
      logic [8:0] r;
      int         s;
      s = 0;
      case (o)
         OP_PASS: r = {1'b0, b};
         OP_ADD: begin
            s = int'(a) + int'(b);
            r = {s > 255, 8'(s)}; // Carry out
         end
         OP_SUB: begin
            s = int'(a) - int'(b);
            r = {a >= b, 8'(s)};  // No borrow means carry set
         end
         OP_AND:  r = {1'b0, a & b};
         OP_OR:   r = {1'b0, a | b};
         OP_XOR:  r = {1'b0, a ^ b};
         OP_INC: begin
            s = int'(a) + 1;
            r = {a == 8'hff, 8'(s)}; // Wraps to zero with carry
         end
         OP_NOT:  r = {1'b0, ~a};
         default: r = '0;
      endcase
      return r;
   endfunction

   // Galois LFSR stepped once per bit
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // ********************
   // Compare process
   // ********************

   // Model steps on the edge and the DUT is read once it has settled
   always @(posedge clk) begin
      if (!rst_n) begin
         model_acc   = '0;
         model_carry = 1'b0;
         for (int i = 0; i < `ACC8_REG_N; i++) begin
            model_regs[i] = '0;
         end
      end else begin
         model_opnd = use_imm ? imm : model_regs[rs]; // Old register contents
         model_next = ref_alu(op, model_acc, model_opnd);
         if (reg_we) begin
            model_regs[rd] = model_acc; // Pre-edge acc
         end
         if (acc_en) begin
            model_carry = model_next[8];
            model_acc   = model_next[7:0];
         end
      end
      #10;
      check_count++;
      if (acc !== model_acc) begin
         $display("CHECK FAILED acc at %0t: got 0x%h, expected 0x%h", $time, acc, model_acc);
         error_count++;
      end
      if (carry !== model_carry) begin
         $display("CHECK FAILED carry at %0t: got 0x%h, expected 0x%h",
                  $time, carry, model_carry);
         error_count++;
      end
   end

   // ********************
   // Stimulus
   // ********************

   // One instruction driven on the falling edge
   task automatic drive_instr(input alu_op_t o, input logic ui, input data_t im,
                              input reg_idx_t s, input logic ae, input logic we,
                              input reg_idx_t d);
      @(negedge clk);
      op      = o;
      use_imm = ui;
      imm     = im;
      rs      = s;
      acc_en  = ae;
      reg_we  = we;
      rd      = d;
   endtask

   task automatic load_imm(input data_t v);
      drive_instr(OP_PASS, 1'b1, v, '0, 1'b1, 1'b0, '0);
   endtask

   // Fill value tied to the full register index
   function automatic data_t fill_value(input int i);
      return data_t'(i * 8'h11) ^ 8'h5a;
   endfunction

   // Every register reads zero after reset
   task automatic read_after_reset();
      for (int i = 0; i < `ACC8_REG_N; i++) begin
         drive_instr(OP_PASS, 1'b0, 8'hee, reg_idx_t'(i), 1'b1, 1'b0, '0);
      end
   endtask

   // All ops over fixed pairs to hit ADD/INC overflow and SUB borrow
   task automatic sweep_opcodes();
      for (int k = 0; k < 8; k++) begin
         for (int p = 0; p < 8; p++) begin
            load_imm(pair_a[p]);
            drive_instr(alu_op_t'(3'(k)), 1'b1, pair_b[p], '0, 1'b1, 1'b0, '0);
         end
      end
   endtask

   // Write each register and read them all back later
   task automatic write_then_read();
      for (int i = 0; i < `ACC8_REG_N; i++) begin
         load_imm(fill_value(i));
         drive_instr(OP_PASS, 1'b1, 8'h00, '0, 1'b0, 1'b1, reg_idx_t'(i)); // acc held
      end
      load_imm(8'h00); // So a read is not mistaken for a held acc
      for (int i = 0; i < `ACC8_REG_N; i++) begin
         drive_instr(OP_PASS, 1'b0, 8'h00, reg_idx_t'(i), 1'b1, 1'b0, '0);
      end
   endtask

   // Write and read one register at the same edge
   task automatic same_cycle_rw();
      for (int i = 0; i < `ACC8_REG_N; i++) begin
         load_imm(~fill_value(i));
         // Read gets fill_value while the write stores the inverse
         drive_instr(OP_PASS, 1'b0, 8'h00, reg_idx_t'(i), 1'b1, 1'b1, reg_idx_t'(i));
         drive_instr(OP_PASS, 1'b0, 8'h00, reg_idx_t'(i), 1'b1, 1'b0, '0);
      end
   endtask

   // Nothing may move while acc_en is low
   task automatic hold_acc();
      logic [31:0] f_op;
      logic [31:0] f_imm;
      logic [31:0] f_rs;
      load_imm(8'hff);
      drive_instr(OP_ADD, 1'b1, 8'h01, '0, 1'b1, 1'b0, '0); // Leaves acc 0 with carry 1
      for (int i = 0; i < n_hold - 2; i++) begin
         draw_bits(3, f_op);
         draw_bits(8, f_imm);
         draw_bits(4, f_rs);
         drive_instr(alu_op_t'(f_op[2:0]), f_imm[0], f_imm[7:0], f_rs[3:0],
                     1'b0, 1'b0, '0);
      end
   endtask

   task automatic random_instr();
      logic [31:0] f_op;
      logic [31:0] f_ui;
      logic [31:0] f_imm;
      logic [31:0] f_rs;
      logic [31:0] f_en;
      logic [31:0] f_we;
      logic [31:0] f_rd;
      draw_bits(3, f_op);
      draw_bits(1, f_ui);
      draw_bits(8, f_imm);
      draw_bits(4, f_rs);
      draw_bits(2, f_en); // acc_en high three times in four
      draw_bits(1, f_we);
      draw_bits(4, f_rd);
      drive_instr(alu_op_t'(f_op[2:0]), f_ui[0], f_imm[7:0], f_rs[3:0],
                  |f_en[1:0], f_we[0], f_rd[3:0]);
   endtask

   initial begin
      op      = OP_PASS;
      use_imm = 1'b0;
      imm     = '0;
      rs      = '0;
      acc_en  = 1'b0;
      reg_we  = 1'b0;
      rd      = '0;
      @(posedge rst_n);
      read_after_reset();
      sweep_opcodes();
      write_then_read();
      same_cycle_rw();
      hold_acc();
      for (int i = 0; i < n_random; i++) begin
         random_instr();
      end
      @(negedge clk); // Last compare has run
      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // ********************
   // Watchdog
   // ********************

   initial begin
      #(timeout);
      $display("Timeout after %0d time units, the test sequence did not finish", timeout);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// File: acc_datapath.f
+incdir+include
hdl/reg_pkg.sv
hdl/alu_pkg.sv
hdl/gate_mux.sv
hdl/reg_bank.sv
hdl/alu8.sv
hdl/acc_datapath.sv
verification/tb_clock.sv
verification/acc_datapath_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log

verilator --binary --timing -j 0 --top-module acc_datapath_tb \
   -f acc_datapath.f -o acc_sim \
   && ./obj_dir/acc_sim | tee sim.log \
   || { echo "Build or simulation run failed"; exit 1; }

grep -q "^NO ERRORS$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
